//--- common/bridge_pkg.sv
package bridge_pkg;

  // default widths, the top level may override them per instance
  localparam int DATA_W = 16;
  localparam int ADDR_W = 4;  // 16 entries, 15 usable

  // one sample as written by the producer
  typedef logic [DATA_W-1:0] sample_t;

  // fill count, one bit wider than the address so a full FIFO fits
  typedef logic [ADDR_W:0] level_t;

  typedef logic [7:0] seq_t;  // frame number, wraps at 256

  typedef logic [15:0] drop_cnt_t;  // saturating

  // word presented to the frame consumer
  typedef struct packed {
    sample_t data;
    seq_t    seq;
    logic    sof;  // first word of a frame
    logic    eof;  // last word of a frame
  } frame_word_t;

  // drain controller states
  typedef enum logic [1:0] {
    IDLE,   // waiting for enough data or a flush
    BURST,  // issuing reads
    GAP     // one idle cycle between bursts
  } drain_state_t;

endpackage

//--- fifo/async_fifo.sv
`timescale 1ns/1ps

module async_fifo #(
  parameter int DATA_W = bridge_pkg::DATA_W,
  parameter int ADDR_W = bridge_pkg::ADDR_W
) (
  input  logic                wr_clk,
  input  logic                rd_clk,
  input  logic                rst,
  input  logic                wr_en,
  input  bridge_pkg::sample_t din,
  input  logic                rd_en,
  output bridge_pkg::sample_t dout,
  output logic                full,
  output logic                empty,
  output bridge_pkg::level_t  rd_level
);

  localparam int DEPTH = 1 << ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];

  // pointers carry one extra wrap bit
  logic [ADDR_W:0] wr_bin, wr_gray;
  logic [ADDR_W:0] rd_bin, rd_gray;
  logic [ADDR_W:0] wr_bin_next, rd_bin_next;

  // two-flop synchronizers for the gray pointers
  logic [ADDR_W:0] rd_gray_s1, rd_gray_s2;  // in wr_clk
  logic [ADDR_W:0] wr_gray_s1, wr_gray_s2;  // in rd_clk

  logic [ADDR_W:0] rd_bin_sync, wr_bin_sync;
  logic [ADDR_W-1:0] wr_addr_next;
  logic wr_ok, rd_ok;

  function automatic logic [ADDR_W:0] gray2bin(input logic [ADDR_W:0] g);
    logic [ADDR_W:0] b;
    b[ADDR_W] = g[ADDR_W];
    for (int i = ADDR_W - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  assign wr_ok = wr_en && !full;
  assign rd_ok = rd_en && !empty;

  assign wr_bin_next = wr_bin + 1'b1;
  assign rd_bin_next = rd_bin + 1'b1;

  // write side
  always_ff @(posedge wr_clk) begin
    if (rst) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
      if (wr_ok) begin
        wr_bin  <= wr_bin_next;
        wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);  // registered, no glitches into sync
      end
    end
  end

  // storage has no reset
  always_ff @(posedge wr_clk) begin
    if (wr_ok) begin
      mem[wr_bin[ADDR_W-1:0]] <= din;
    end
  end

  // read side
  always_ff @(posedge rd_clk) begin
    if (rst) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
      if (rd_ok) begin
        rd_bin  <= rd_bin_next;
        rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
      end
    end
  end

  always_ff @(posedge rd_clk) begin
    if (rd_ok) begin
      dout <= mem[rd_bin[ADDR_W-1:0]];  // valid after the accepting edge
    end
  end

  assign rd_bin_sync = gray2bin(rd_gray_s2);
  assign wr_bin_sync = gray2bin(wr_gray_s2);

  // full one entry short of the array, so depth-1 words are usable
  assign wr_addr_next = wr_bin[ADDR_W-1:0] + 1'b1;
  assign full         = (wr_addr_next == rd_bin_sync[ADDR_W-1:0]);

  assign empty    = (rd_bin == wr_bin_sync);
  assign rd_level = bridge_pkg::level_t'(wr_bin_sync - rd_bin);  // lags the true fill

endmodule

//--- hw/drain_ctrl.sv
`timescale 1ns/1ps

module drain_ctrl #(
  parameter int BURST = 4
) (
  input  logic               rd_clk,
  input  logic               rst,
  input  logic               drain_en,
  input  logic               flush,
  input  logic               empty,
  input  bridge_pkg::level_t rd_level,
  output logic               rd_en,
  output logic               rd_first,
  output logic               rd_last
);

  localparam bridge_pkg::level_t BURST_LVL = bridge_pkg::level_t'(BURST);

  bridge_pkg::drain_state_t state;

  bridge_pkg::level_t cnt;        // reads still to issue in this burst
  bridge_pkg::level_t burst_len;

  logic first_q;      // next read is the first of the burst
  logic flush_pend;   // flush seen, not yet served
  logic flush_frame;  // current burst serves the flush
  logic level_ok;
  logic start_normal;
  logic start_flush;

  assign level_ok  = (rd_level >= BURST_LVL);

  assign start_normal = drain_en && level_ok;
  assign start_flush  = flush_pend && !empty;

  // rd_level only lags, so this many reads always find data
  assign burst_len = level_ok ? BURST_LVL : rd_level;

  always_ff @(posedge rd_clk) begin
    if (rst) begin
      state       <= bridge_pkg::IDLE;
      cnt         <= '0;
      first_q     <= 1'b0;
      flush_frame <= 1'b0;
    end else begin
      case (state)
        bridge_pkg::IDLE: begin
          if (start_normal || start_flush) begin
            state       <= bridge_pkg::BURST;
            cnt         <= burst_len;
            first_q     <= 1'b1;
            flush_frame <= flush_pend;
          end
        end
        bridge_pkg::BURST: begin
          first_q <= 1'b0;
          cnt     <= cnt - 1'b1;
          if (cnt == bridge_pkg::level_t'(1)) begin
            state <= bridge_pkg::GAP;
          end
        end
        bridge_pkg::GAP: begin
          state       <= bridge_pkg::IDLE;
          flush_frame <= 1'b0;
        end
        default: state <= bridge_pkg::IDLE;
      endcase
    end
  end

  // flush latch, a new request wins over the clear
  always_ff @(posedge rd_clk) begin
    if (rst) begin
      flush_pend <= 1'b0;
    end else if (flush) begin
      flush_pend <= 1'b1;
    end else if (rd_last && flush_frame) begin
      flush_pend <= 1'b0;
    end
  end

  assign rd_en    = (state == bridge_pkg::BURST);
  assign rd_first = rd_en && first_q;
  assign rd_last  = rd_en && (cnt == bridge_pkg::level_t'(1));

endmodule

//--- hw/frame_assembler.sv
`timescale 1ns/1ps

module frame_assembler (
  input  logic                    rd_clk,
  input  logic                    rst,
  input  logic                    rd_en,
  input  logic                    rd_first,
  input  logic                    rd_last,
  input  bridge_pkg::sample_t     dout,
  output logic                    out_valid,
  output bridge_pkg::frame_word_t out_word,
  output bridge_pkg::sample_t     out_sum
);

  // read strobes delayed to the cycle where dout holds the data
  logic v_q;
  logic first_q;
  logic last_q;

  bridge_pkg::seq_t seq_cnt;

  always_ff @(posedge rd_clk) begin
    if (rst) begin
      v_q     <= 1'b0;
      first_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      v_q     <= rd_en;
      first_q <= rd_first;
      last_q  <= rd_last;
    end
  end

  // output stage, two cycles after rd_en
  always_ff @(posedge rd_clk) begin
    if (rst) begin
      out_valid    <= 1'b0;
      out_word.sof <= 1'b0;
      out_word.eof <= 1'b0;
      out_word.seq <= '0;
      seq_cnt      <= '0;
    end else begin
      out_valid    <= v_q;
      out_word.sof <= v_q && first_q;
      out_word.eof <= v_q && last_q;
      if (v_q) begin
        out_word.data <= dout;
        out_word.seq  <= seq_cnt;  // eof word still carries this frame's number
      end
      if (v_q && last_q) begin
        seq_cnt <= seq_cnt + 1'b1;  // wraps at 256
      end
    end
  end

  // running checksum, restarts on the first word
  // only meaningful on the eof cycle
  always_ff @(posedge rd_clk) begin
    if (v_q) begin
      out_sum <= first_q ? dout : (out_sum ^ dout);
    end
  end

endmodule

//--- hw/overflow_monitor.sv
`timescale 1ns/1ps

module overflow_monitor (
  input  logic                  wr_clk,
  input  logic                  rst,
  input  logic                  wr_en,
  input  logic                  full,
  output bridge_pkg::drop_cnt_t drop_cnt,
  output logic                  overflow
);

  logic dropped;

  assign dropped = wr_en && full;  // the FIFO ignores this write

  always_ff @(posedge wr_clk) begin
    if (rst) begin
      drop_cnt <= '0;
      overflow <= 1'b0;
    end else if (dropped) begin
      overflow <= 1'b1;  // sticky until reset
      if (drop_cnt != '1) begin
        drop_cnt <= drop_cnt + 1'b1;
      end
    end
  end

endmodule

//--- hw/sample_bridge_top.sv
`timescale 1ns/1ps

module sample_bridge_top #(
  parameter int DATA_W = bridge_pkg::DATA_W,
  parameter int ADDR_W = bridge_pkg::ADDR_W,
  parameter int BURST  = 4
) (
  input  logic                    wr_clk,
  input  logic                    rd_clk,
  input  logic                    rst,
  // write side
  input  logic                    wr_en,
  input  bridge_pkg::sample_t     din,
  output logic                    full,
  output bridge_pkg::drop_cnt_t   drop_cnt,
  output logic                    overflow,
  // read side
  input  logic                    drain_en,
  input  logic                    flush,
  output logic                    out_valid,
  output bridge_pkg::frame_word_t out_word,
  output bridge_pkg::sample_t     out_sum,
  output logic                    empty
);

  logic                rd_en;
  logic                rd_first;
  logic                rd_last;
  bridge_pkg::level_t  rd_level;
  bridge_pkg::sample_t dout;

  async_fifo #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W)
  ) fifo_i (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .rst      (rst),
    .wr_en    (wr_en),
    .din      (din),
    .rd_en    (rd_en),
    .dout     (dout),
    .full     (full),
    .empty    (empty),
    .rd_level (rd_level)
  );

  drain_ctrl #(
    .BURST (BURST)
  ) drain_i (
    .rd_clk   (rd_clk),
    .rst      (rst),
    .drain_en (drain_en),
    .flush    (flush),
    .empty    (empty),
    .rd_level (rd_level),
    .rd_en    (rd_en),
    .rd_first (rd_first),
    .rd_last  (rd_last)
  );

  frame_assembler frame_i (
    .rd_clk    (rd_clk),
    .rst       (rst),
    .rd_en     (rd_en),
    .rd_first  (rd_first),
    .rd_last   (rd_last),
    .dout      (dout),
    .out_valid (out_valid),
    .out_word  (out_word),
    .out_sum   (out_sum)
  );

  overflow_monitor ovf_i (
    .wr_clk   (wr_clk),
    .rst      (rst),
    .wr_en    (wr_en),
    .full     (full),
    .drop_cnt (drop_cnt),
    .overflow (overflow)
  );

endmodule

//--- tests/sample_bridge_props.sv
`timescale 1ns/1ps

module sample_bridge_props #(
  parameter int BURST = 4
) (
  input logic                    rd_clk,
  input logic                    rst,
  input logic                    drain_en,
  input logic                    flush_pend,
  input logic                    out_valid,
  input bridge_pkg::frame_word_t out_word,
  input logic                    full,
  input logic                    empty,
  input logic                    overflow,
  input bridge_pkg::drop_cnt_t   drop_cnt
);

  // a burst started before this window has left the output by its last cycle
  localparam int QUIET = BURST + 3;

  int fail_cnt = 0;  // watched by the testbench

  strobes_need_valid: assert property (@(posedge rd_clk) disable iff (rst)
    (out_word.sof || out_word.eof) |-> out_valid)
  else begin
    $error("sof or eof strobe without out_valid");
    fail_cnt++;
  end

  no_output_when_idle: assert property (@(posedge rd_clk) disable iff (rst)
    (!drain_en && !flush_pend) [*QUIET] |-> !out_valid)
  else begin
    $error("out_valid while draining is off and no flush is pending");
    fail_cnt++;
  end

  flags_after_reset: assert property (@(posedge rd_clk)
    $fell(rst) |-> !out_valid && !full && empty && !overflow && drop_cnt == '0)
  else begin
    $error("flags not at their reset values when reset ends");
    fail_cnt++;
  end

endmodule

bind sample_bridge_top sample_bridge_props #(.BURST(BURST)) props_i (
  .rd_clk     (rd_clk),
  .rst        (rst),
  .drain_en   (drain_en),
  .flush_pend (drain_i.flush_pend),
  .out_valid  (out_valid),
  .out_word   (out_word),
  .full       (full),
  .empty      (empty),
  .overflow   (overflow),
  .drop_cnt   (drop_cnt)
);

//--- tests/tb_sample_bridge.sv
`timescale 1ns/1ps

module tb_sample_bridge;

  localparam int BURST       = 4;
  localparam int USABLE      = (1 << bridge_pkg::ADDR_W) - 1;  // one slot always free
  localparam int RAND_WRITES = 1100;
  localparam int FILL_WRITES = 20;
  // random traffic takes about 2100 rd_clk cycles, the other phases under 200
  localparam int TIMEOUT_CYCLES = 4000;

  logic rd_clk = 1'b0;
  logic wr_clk = 1'b0;
  logic rst    = 1'b1;
  logic wr_en;
  logic drain_en;
  logic flush;
  bridge_pkg::sample_t     din;
  logic                    full;
  bridge_pkg::drop_cnt_t   drop_cnt;
  logic                    overflow;
  logic                    out_valid;
  bridge_pkg::frame_word_t out_word;
  bridge_pkg::sample_t     out_sum;
  logic                    empty;

  bridge_pkg::sample_t model_q[$];  // accepted, not yet delivered
  bridge_pkg::sample_t exp_data;
  bridge_pkg::sample_t exp_sum;
  bridge_pkg::seq_t    exp_seq;
  int frame_pos = 0;  // words of the current frame seen so far
  int exp_len   = BURST;
  int exp_drops = 0;
  int cycles    = 0;
  logic [15:0] lfsr = 16'd23174;

  always #20 rd_clk = ~rd_clk;
  always #15 wr_clk = ~wr_clk;

  sample_bridge_top #(.BURST(BURST)) dut_i (
    .wr_clk    (wr_clk),
    .rd_clk    (rd_clk),
    .rst       (rst),
    .wr_en     (wr_en),
    .din       (din),
    .full      (full),
    .drop_cnt  (drop_cnt),
    .overflow  (overflow),
    .drain_en  (drain_en),
    .flush     (flush),
    .out_valid (out_valid),
    .out_word  (out_word),
    .out_sum   (out_sum),
    .empty     (empty)
  );

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic value_mismatch(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
    $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    abort_run();
  endtask

  // galois lfsr, x^16+x^14+x^13+x^11+1
  function automatic logic [15:0] lfsr_bits(input int n);
    logic [15:0] val;
    logic        b;
    val = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = (lfsr >> 1) ^ (b ? 16'hB400 : 16'h0000);
      val  = {val[14:0], b};
    end
    return val;
  endfunction

  task automatic write_sample(input bridge_pkg::sample_t data, output logic ok);
    @(negedge wr_clk);
    wr_en = 1'b1;
    din   = data;
    ok    = !full;  // full only moves on wr_clk rising edges
    if (ok) begin
      model_q.push_back(data);
    end else begin
      exp_drops++;
    end
  endtask

  task automatic idle_wr(input int n);
    repeat (n) begin
      @(negedge wr_clk);
      wr_en = 1'b0;
    end
  endtask

  // wait for whole bursts to finish, then flush the rest as one short frame
  task automatic flush_rest();
    @(posedge rd_clk);
    while (model_q.size() >= BURST || frame_pos != 0) @(posedge rd_clk);
    repeat (6) @(posedge rd_clk);  // rd_level catches up with the last writes
    exp_len = model_q.size();
    if (exp_len > 0) begin
      @(negedge rd_clk);
      flush = 1'b1;
      @(negedge rd_clk);
      flush = 1'b0;
      while (model_q.size() != 0) @(posedge rd_clk);
    end
    repeat (4) @(negedge rd_clk);
    assert (empty == 1'b1) else value_mismatch("empty", 1, empty);
    exp_len = BURST;
  endtask

  // output checker against the queue model
  always @(negedge rd_clk) begin
    if (dut_i.props_i.fail_cnt != 0) begin
      $display("a protocol assertion on the DUT fired, see the error above");
      abort_run();
    end else if (!rst && out_valid) begin
      if (model_q.size() == 0) begin
        $display("output word at %0t with no accepted sample left to deliver", $time);
        abort_run();
      end else begin
        exp_data = model_q.pop_front();
        exp_sum  = (frame_pos == 0) ? exp_data : (exp_sum ^ exp_data);
        assert (out_word.data == exp_data)
          else value_mismatch("out_word.data", exp_data, out_word.data);
        assert (out_word.sof == (frame_pos == 0))
          else value_mismatch("out_word.sof", frame_pos == 0, out_word.sof);
        assert (out_word.eof == (frame_pos + 1 == exp_len))
          else value_mismatch("out_word.eof", frame_pos + 1 == exp_len, out_word.eof);
        assert (out_word.seq == exp_seq)
          else value_mismatch("out_word.seq", exp_seq, out_word.seq);
        if (frame_pos + 1 == exp_len) begin
          assert (out_sum == exp_sum) else value_mismatch("out_sum", exp_sum, out_sum);
          exp_seq++;  // wraps at 256
          frame_pos = 0;
        end else begin
          frame_pos++;
        end
      end
    end
  end

  always @(posedge rd_clk) begin
    cycles++;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout, the run did not finish within %0d rd_clk cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  initial begin
    logic ok;
    int   n_acc;
    wr_en    = 1'b0;
    din      = '0;
    drain_en = 1'b0;
    flush    = 1'b0;
    exp_seq  = '0;
    repeat (10) @(negedge rd_clk);
    rst = 1'b0;

    @(negedge rd_clk);
    assert (out_valid == 1'b0) else value_mismatch("out_valid", 0, out_valid);
    assert (full == 1'b0) else value_mismatch("full", 0, full);
    assert (empty == 1'b1) else value_mismatch("empty", 1, empty);
    assert (drop_cnt == '0) else value_mismatch("drop_cnt", 0, drop_cnt);

    // random gaps and data with draining on
    drain_en = 1'b1;
    for (int i = 0; i < RAND_WRITES; i++) begin
      idle_wr(lfsr_bits(2));
      write_sample(lfsr_bits(bridge_pkg::DATA_W), ok);
    end
    idle_wr(1);
    flush_rest();

    // overfill with draining off
    @(negedge rd_clk);
    drain_en = 1'b0;
    n_acc    = 0;
    for (int i = 0; i < FILL_WRITES; i++) begin
      write_sample(lfsr_bits(bridge_pkg::DATA_W), ok);
      assert (full == (n_acc >= USABLE)) else value_mismatch("full", n_acc >= USABLE, full);
      n_acc += ok;
    end
    idle_wr(3);
    assert (drop_cnt == exp_drops) else value_mismatch("drop_cnt", exp_drops, drop_cnt);
    assert (overflow == 1'b1) else value_mismatch("overflow", 1, overflow);

    // whole frames first, then the short remainder
    @(negedge rd_clk);
    drain_en = 1'b1;
    flush_rest();
    repeat (20) @(negedge rd_clk);  // a late word trips the checker

    if (model_q.size() != 0) begin
      $display("%0d accepted samples never reached the output", model_q.size());
      abort_run();
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

//--- flist.f
common/bridge_pkg.sv
fifo/async_fifo.sv
hw/drain_ctrl.sv
hw/frame_assembler.sv
hw/overflow_monitor.sv
hw/sample_bridge_top.sv
tests/sample_bridge_props.sv
tests/tb_sample_bridge.sv
